// ==== Makefile ====
# Verilator build of the register subsystem testbench
TOP := tb_reg_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== src/bus_ctrl.sv ====
/* bus controller running the four-phase request/acknowledge handshake, decoding the
   target block and issuing one read or write strobe per transfer */
`timescale 1ns/1ps
`include "bus_macros.svh"

module bus_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       bus_req,
    input  bus_pkg::rw_t               bus_rw,
    input  logic [`BUS_ADDR_WIDTH-1:0] bus_addr,
    input  sys_pkg::word_t             bus_wdata,
    output logic                       bus_ack,
    output logic                       rd_strobe,
    output logic                       wr_strobe,
    output logic                       access_fault,
    output bus_pkg::ctrl_phase_t       phase,
    output sys_pkg::target_t           target,
    output sys_pkg::local_idx_t        local_idx,
    output sys_pkg::word_t             wr_data
);
    import bus_pkg::*;
    import sys_pkg::*;

    ctrl_phase_t                phase_next;
    logic                       start;
    rw_t                        rw_q;
    logic [`BUS_ADDR_WIDTH-1:0] addr_q;
    word_t                      wdata_q;
    // offset of the latched address from each block base
    logic [`BUS_ADDR_WIDTH-1:0] info_off;
    logic [`BUS_ADDR_WIDTH-1:0] pwm_off;

    // a new transfer is accepted only from idle
    assign start = (phase == PH_IDLE) && bus_req;

    always_comb begin
        phase_next = phase;
        case (phase)
            PH_IDLE: begin
                if (bus_req) begin
                    phase_next = PH_ACCESS;
                end
            end
            PH_ACCESS: begin
                phase_next = PH_RESPOND;
            end
            // host back-pressure keeps us here while bus_req stays high
            PH_RESPOND: begin
                if (!bus_req) begin
                    phase_next = PH_RELEASE;
                end
            end
            default: begin
                phase_next = PH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            phase   <= PH_IDLE;
            rw_q    <= RW_READ;
            addr_q  <= '0;
            wdata_q <= '0;
        end else begin
            phase <= phase_next;
            if (start) begin
                rw_q    <= bus_rw;
                addr_q  <= bus_addr;
                wdata_q <= bus_wdata;
            end
        end
    end

    // wrapping subtraction turns the address decode into an unsigned range check
    assign info_off = addr_q - `SYS_INFO_BASE;
    assign pwm_off  = addr_q - `PWM_BASE;

    always_comb begin
        target    = TGT_NONE;
        local_idx = '0;
        if (info_off < `SYS_INFO_NUM_REGS) begin
            target    = TGT_SYS_INFO;
            local_idx = info_off[$bits(local_idx_t)-1:0];
        end else if (pwm_off < `PWM_NUM_REGS) begin
            target    = TGT_PWM;
            local_idx = pwm_off[$bits(local_idx_t)-1:0];
        end
    end

    // unmapped address or write into the read-only block
    assign access_fault = (target == TGT_NONE) ||
                          ((target == TGT_SYS_INFO) && (rw_q == RW_WRITE));

    assign rd_strobe = (phase == PH_ACCESS) && !access_fault && (rw_q == RW_READ);
    assign wr_strobe = (phase == PH_ACCESS) && !access_fault && (rw_q == RW_WRITE);
    assign bus_ack   = (phase == PH_RESPOND) || (phase == PH_RELEASE);
    assign wr_data   = wdata_q;

    // strobes are single-cycle pulses
    a_strobe_pulse: assert property (@(posedge clk) disable iff (!reset)
        (rd_strobe || wr_strobe) |=> !(rd_strobe || wr_strobe))
        else $error("strobe held longer than one cycle");

    a_strobe_onehot: assert property (@(posedge clk) disable iff (!reset)
        !(rd_strobe && wr_strobe))
        else $error("read and write strobe together");

    // subsystems are never touched while the host sees an acknowledge
    a_no_strobe_in_ack: assert property (@(posedge clk) disable iff (!reset)
        bus_ack |-> !(rd_strobe || wr_strobe))
        else $error("strobe during acknowledge");

endmodule

// ==== src/bus_macros.svh ====
/* register bus constants: widths, register map and the fixed
   identification words of the system information block */
`ifndef BUS_MACROS_SVH
`define BUS_MACROS_SVH

// bus widths
`define BUS_ADDR_WIDTH        8
`define BUS_DATA_WIDTH        32

// block bases and number of decoded registers per block
`define SYS_INFO_BASE         8'h00
`define SYS_INFO_NUM_REGS     4
`define PWM_BASE              8'h10
`define PWM_NUM_REGS          3

// sys_info local indices and contents
`define SYS_INFO_ID_IDX       4'd0
`define SYS_INFO_VERSION_IDX  4'd1
`define SYS_INFO_COUNT_IDX    4'd2
`define SYS_INFO_RDCNT_IDX    4'd3
`define SYS_INFO_RDCNT_WIDTH  16
`define SYS_INFO_ID           32'h5359_5301
`define SYS_INFO_VERSION      32'h0001_0000
`define SYS_INFO_COUNT        32'h2

// pwm local indices, ctrl bit 0 enables the counter
`define PWM_PERIOD_IDX        4'd0
`define PWM_DUTY_IDX          4'd1
`define PWM_CTRL_IDX          4'd2
`define PWM_CTRL_EN_BIT       0

`endif

// ==== src/bus_pkg.sv ====
/* bus_pkg: handshake-side types of the register bus,
   transfer direction and bus controller phases */
package bus_pkg;

    // direction of one host transfer
    typedef enum logic {
        RW_READ  = 1'b0,
        RW_WRITE = 1'b1
    } rw_t;

    // four-phase handshake states of the controller
    // idle   waiting for bus_req
    // access strobe cycle, response block samples read data
    // respond bus_ack high until the host drops bus_req
    // release one more ack cycle before going idle
    typedef enum logic [1:0] {
        PH_IDLE    = 2'd0,
        PH_ACCESS  = 2'd1,
        PH_RESPOND = 2'd2,
        PH_RELEASE = 2'd3
    } ctrl_phase_t;

endpackage

// ==== src/bus_response.sv ====
/* bus_response: picks the read word of the addressed block and holds
   it with the active-low fault flag while the host is acknowledged */
`timescale 1ns/1ps

module bus_response (
    input  logic                 clk,
    input  logic                 reset,
    input  bus_pkg::ctrl_phase_t phase,
    input  sys_pkg::target_t     target,
    input  logic                 access_fault,
    input  sys_pkg::word_t       info_rdata,
    input  sys_pkg::word_t       pwm_rdata,
    output sys_pkg::word_t       bus_rdata,
    output logic                 bus_fault_n
);
    import bus_pkg::*;
    import sys_pkg::*;

    word_t sel_rdata;

    // read mux in place of a shared tri-state bus
    always_comb begin
        case (target)
            TGT_SYS_INFO: sel_rdata = info_rdata;
            TGT_PWM:      sel_rdata = pwm_rdata;
            default:      sel_rdata = '0;
        endcase
    end

    // capture in the strobe cycle, hold through respond and release
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            bus_rdata   <= '0;
            bus_fault_n <= 1'b1;
        end else if (phase == PH_ACCESS) begin
            // writes see zero here since the pwm block blanks its readback
            bus_rdata   <= access_fault ? '0 : sel_rdata;
            bus_fault_n <= !access_fault;
        end else if (phase == PH_IDLE) begin
            bus_rdata   <= '0;
            bus_fault_n <= 1'b1;
        end
    end

endmodule

// ==== src/pwm_block.sv ====
/* pwm_block: period, duty and control registers driving a
   free-running counter and a registered PWM output */
`timescale 1ns/1ps
`include "bus_macros.svh"

module pwm_block (
    input  logic                clk,
    input  logic                reset,
    input  logic                wr_strobe,
    input  logic                sel,
    input  sys_pkg::local_idx_t local_idx,
    input  sys_pkg::word_t      wr_data,
    output sys_pkg::word_t      rdata,
    output logic                pwm_out
);
    import sys_pkg::*;

    word_t period;
    word_t duty;
    word_t ctrl;
    word_t cnt;
    logic  wr_en;
    logic  enable;

    assign wr_en = wr_strobe && sel;

    // a zero period would never wrap, treat it as disabled
    assign enable = ctrl[`PWM_CTRL_EN_BIT] && (period != '0);

    // register writes land at the end of the strobe cycle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            period <= '0;
            duty   <= '0;
            ctrl   <= '0;
        end else if (wr_en) begin
            case (local_idx)
                `PWM_PERIOD_IDX: period <= wr_data;
                `PWM_DUTY_IDX:   duty   <= wr_data;
                `PWM_CTRL_IDX:   ctrl   <= wr_data;
                default:         ;
            endcase
        end
    end

    // counter wraps at period-1, >= also catches a period
    // shortened below the running count
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cnt     <= '0;
            pwm_out <= 1'b0;
        end else if (!enable) begin
            cnt     <= '0;
            pwm_out <= 1'b0;
        end else begin
            if (cnt >= period - 1'b1) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            pwm_out <= (cnt < duty);
        end
    end

    // readback, a write cycle presents zero so writes return no data
    always_comb begin
        rdata = '0;
        if (!wr_en) begin
            case (local_idx)
                `PWM_PERIOD_IDX: rdata = period;
                `PWM_DUTY_IDX:   rdata = duty;
                `PWM_CTRL_IDX:   rdata = ctrl;
                default:         rdata = '0;
            endcase
        end
    end

    // with a steady period the count never reaches it
    a_cnt_in_period: assert property (@(posedge clk) disable iff (!reset)
        (enable && $stable(period)) |-> (cnt < period))
        else $error("pwm counter out of period");

endmodule

// ==== src/reg_subsystem_top.sv ====
/* reg_subsystem_top: register subsystem with handshake controller,
   information and PWM blocks and the read response path */
`timescale 1ns/1ps
`include "bus_macros.svh"

module reg_subsystem_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       bus_req,
    input  bus_pkg::rw_t               bus_rw,
    input  logic [`BUS_ADDR_WIDTH-1:0] bus_addr,
    input  sys_pkg::word_t             bus_wdata,
    output logic                       bus_ack,
    output sys_pkg::word_t             bus_rdata,
    output logic                       bus_fault_n,
    output logic                       pwm_out
);
    import bus_pkg::*;
    import sys_pkg::*;

    ctrl_phase_t phase;
    target_t     target;
    local_idx_t  local_idx;
    word_t       wr_data;
    word_t       info_rdata;
    word_t       pwm_rdata;
    logic        rd_strobe;
    logic        wr_strobe;
    logic        access_fault;
    logic        info_sel;
    logic        pwm_sel;

    // per-block select from the decoded target
    assign info_sel = (target == TGT_SYS_INFO);
    assign pwm_sel  = (target == TGT_PWM);

    bus_ctrl u_bus_ctrl (
        .clk          (clk),
        .reset        (reset),
        .bus_req      (bus_req),
        .bus_rw       (bus_rw),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .bus_ack      (bus_ack),
        .rd_strobe    (rd_strobe),
        .wr_strobe    (wr_strobe),
        .access_fault (access_fault),
        .phase        (phase),
        .target       (target),
        .local_idx    (local_idx),
        .wr_data      (wr_data)
    );

    sys_info u_sys_info (
        .clk       (clk),
        .reset     (reset),
        .rd_strobe (rd_strobe),
        .sel       (info_sel),
        .local_idx (local_idx),
        .rdata     (info_rdata)
    );

    pwm_block u_pwm_block (
        .clk       (clk),
        .reset     (reset),
        .wr_strobe (wr_strobe),
        .sel       (pwm_sel),
        .local_idx (local_idx),
        .wr_data   (wr_data),
        .rdata     (pwm_rdata),
        .pwm_out   (pwm_out)
    );

    bus_response u_bus_response (
        .clk          (clk),
        .reset        (reset),
        .phase        (phase),
        .target       (target),
        .access_fault (access_fault),
        .info_rdata   (info_rdata),
        .pwm_rdata    (pwm_rdata),
        .bus_rdata    (bus_rdata),
        .bus_fault_n  (bus_fault_n)
    );

endmodule

// ==== src/sys_info.sv ====
/* sys_info: read-only identification registers, plus a saturating
   read counter kept as a diagnostic register */
`timescale 1ns/1ps
`include "bus_macros.svh"

module sys_info (
    input  logic                clk,
    input  logic                reset,
    input  logic                rd_strobe,
    input  logic                sel,
    input  sys_pkg::local_idx_t local_idx,
    output sys_pkg::word_t      rdata
);
    import sys_pkg::*;

    // counts reads of this block, sticks at all ones
    logic [`SYS_INFO_RDCNT_WIDTH-1:0] rd_count;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rd_count <= '0;
        end else if (rd_strobe && sel && !(&rd_count)) begin
            rd_count <= rd_count + 1'b1;
        end
    end

    // read data is combinational, so the counter index shows
    // the number of reads before the current one
    always_comb begin
        case (local_idx)
            `SYS_INFO_ID_IDX: begin
                rdata = `SYS_INFO_ID;
            end
            `SYS_INFO_VERSION_IDX: begin
                rdata = `SYS_INFO_VERSION;
            end
            `SYS_INFO_COUNT_IDX: begin
                rdata = `SYS_INFO_COUNT;
            end
            `SYS_INFO_RDCNT_IDX: begin
                rdata = word_t'(rd_count);
            end
            default: begin
                rdata = '0;
            end
        endcase
    end

    // a read strobe aimed at another block leaves the counter alone
    a_read_needs_sel: assert property (@(posedge clk) disable iff (!reset)
        (rd_strobe && !sel) |=> $stable(rd_count))
        else $error("sys_info counted a read while deselected");

endmodule

// ==== src/sys_pkg.sv ====
/* sys_pkg: subsystem-side types, the data word, the decoded
   target block and the register index inside a block */
`include "bus_macros.svh"

package sys_pkg;

    // one register data word
    typedef logic [`BUS_DATA_WIDTH-1:0] word_t;

    // subsystem that owns the current address
    typedef enum logic [1:0] {
        TGT_NONE     = 2'd0,
        TGT_SYS_INFO = 2'd1,
        TGT_PWM      = 2'd2
    } target_t;

    // register offset from the block base
    typedef logic [3:0] local_idx_t;

endpackage

// ==== verification/tb_reg_subsystem.sv ====
/* self-checking testbench for the register subsystem with random host transfers
   against a register-map model plus PWM window checks */
`timescale 1ns/1ps
`include "bus_macros.svh"

module tb_reg_subsystem;
    import bus_pkg::*;
    import sys_pkg::*;

    localparam int CLK_PERIOD    = 8;
    localparam int NUM_RANDOM    = 300;
    localparam int NUM_PWM_CASES = 8;
    // directed reads, random transfers and six transfers per pwm case
    localparam int NUM_TRANSFERS = 6 + NUM_RANDOM + NUM_PWM_CASES * 6;
    // settle, count window and disabled check at the largest period
    localparam int PWM_CYCLES    = NUM_PWM_CASES * (41 + 40 + 90);
    localparam int TIMEOUT_CYCLES = 16 + NUM_TRANSFERS * 20 + PWM_CYCLES + 200;

    logic                       clk;
    logic                       reset;
    logic                       bus_req;
    rw_t                        bus_rw;
    logic [`BUS_ADDR_WIDTH-1:0] bus_addr;
    word_t                      bus_wdata;
    logic                       bus_ack;
    word_t                      bus_rdata;
    logic                       bus_fault_n;
    logic                       pwm_out;

    // register-map model of the pwm registers and the reads seen by sys_info
    word_t       pwm_regs [0:2];
    int unsigned info_reads;

    reg_subsystem_top uut (
        .clk         (clk),
        .reset       (reset),
        .bus_req     (bus_req),
        .bus_rw      (bus_rw),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .bus_ack     (bus_ack),
        .bus_rdata   (bus_rdata),
        .bus_fault_n (bus_fault_n),
        .pwm_out     (pwm_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("CHECKS FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input word_t got, input word_t expected);
        assert (got === expected) else begin
            $display("Error: %s = %h, expected %h", name, got, expected);
            abort_run("value mismatch");
        end
    endtask

    // one four-phase transfer that starts and ends just after a falling edge
    task automatic host_transfer(input rw_t rw, input logic [7:0] addr, input word_t wdata,
                                 output word_t rdata, output logic fault_n);
        int unsigned hold;
        hold = $urandom_range(4, 0);
        bus_rw    = rw;
        bus_addr  = addr;
        bus_wdata = wdata;
        bus_req   = 1'b1;
        // ack stays low for the cycle after the request is seen
        @(negedge clk);
        check_value("bus_ack", word_t'(bus_ack), 32'h0);
        // one cycle later the response is up
        @(negedge clk);
        check_value("bus_ack", word_t'(bus_ack), 32'h1);
        rdata   = bus_rdata;
        fault_n = bus_fault_n;
        // response stays put under host back-pressure
        repeat (hold) begin
            @(negedge clk);
            check_value("bus_ack", word_t'(bus_ack), 32'h1);
            check_value("bus_rdata", bus_rdata, rdata);
            check_value("bus_fault_n", word_t'(bus_fault_n), word_t'(fault_n));
        end
        bus_req = 1'b0;
        // release phase still acknowledges
        @(negedge clk);
        check_value("bus_ack", word_t'(bus_ack), 32'h1);
        check_value("bus_rdata", bus_rdata, rdata);
        @(negedge clk);
        check_value("bus_ack", word_t'(bus_ack), 32'h0);
    endtask

    // predict the response, run the transfer, compare
    task automatic checked_access(input rw_t rw, input logic [7:0] addr, input word_t wdata);
        word_t exp_data;
        logic  exp_fault_n;
        word_t got_data;
        logic  got_fault_n;
        exp_data    = '0;
        exp_fault_n = 1'b1;
        if (addr <= `SYS_INFO_BASE + 8'h03) begin
            // index 3 of the read-only block counts earlier reads
            if (rw == RW_WRITE) begin
                exp_fault_n = 1'b0;
            end else begin
                case (addr - `SYS_INFO_BASE)
                    8'h00:   exp_data = `SYS_INFO_ID;
                    8'h01:   exp_data = `SYS_INFO_VERSION;
                    8'h02:   exp_data = `SYS_INFO_COUNT;
                    default: exp_data = info_reads;
                endcase
                if (info_reads < 32'hffff) begin
                    info_reads++;
                end
            end
        end else if (addr >= `PWM_BASE && addr <= `PWM_BASE + 8'h02) begin
            if (rw == RW_WRITE) begin
                pwm_regs[2'(addr - `PWM_BASE)] = wdata;
            end else begin
                exp_data = pwm_regs[2'(addr - `PWM_BASE)];
            end
        end else begin
            exp_fault_n = 1'b0;
        end
        host_transfer(rw, addr, wdata, got_data, got_fault_n);
        check_value("bus_rdata", got_data, exp_data);
        check_value("bus_fault_n", word_t'(got_fault_n), word_t'(exp_fault_n));
    endtask

    // count high cycles of pwm_out over one period window
    task automatic pwm_window_test(input int unsigned period, input int unsigned duty);
        int unsigned high_count;
        int unsigned expected;
        expected = (duty < period) ? duty : period;
        checked_access(RW_WRITE, `PWM_BASE + `PWM_CTRL_IDX, 32'h0);
        checked_access(RW_WRITE, `PWM_BASE + `PWM_PERIOD_IDX, period);
        checked_access(RW_WRITE, `PWM_BASE + `PWM_DUTY_IDX, duty);
        checked_access(RW_WRITE, `PWM_BASE + `PWM_CTRL_IDX, 32'h1);
        checked_access(RW_READ, `PWM_BASE + `PWM_PERIOD_IDX, 32'h0);
        // let one full period pass before counting
        repeat (period + 1) @(negedge clk);
        high_count = 0;
        repeat (period) begin
            @(negedge clk);
            if (pwm_out) begin
                high_count++;
            end
        end
        check_value("pwm_out high count", high_count, expected);
        // disabled block keeps the output low
        checked_access(RW_WRITE, `PWM_BASE + `PWM_CTRL_IDX, 32'h0);
        repeat (2 * period + 10) begin
            @(negedge clk);
            check_value("pwm_out", word_t'(pwm_out), 32'h0);
        end
    endtask

    // watchdog sized from the transfer count and pwm windows
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        logic [7:0] addr;
        rw_t        rw;
        void'($urandom(32'hcac2_422c));
        reset      = 1'b0;
        bus_req    = 1'b0;
        bus_rw     = RW_READ;
        bus_addr   = '0;
        bus_wdata  = '0;
        info_reads = 0;
        for (int i = 0; i < 3; i++) begin
            pwm_regs[i] = '0;
        end
        repeat (16) @(negedge clk);
        reset = 1'b1;
        @(negedge clk);

        // reset values
        check_value("bus_ack", word_t'(bus_ack), 32'h0);
        check_value("pwm_out", word_t'(pwm_out), 32'h0);
        check_value("bus_fault_n", word_t'(bus_fault_n), 32'h1);
        check_value("bus_rdata", bus_rdata, 32'h0);

        // constant words and then the read counter twice
        checked_access(RW_READ, `SYS_INFO_BASE + 8'h00, 32'h0);
        checked_access(RW_READ, `SYS_INFO_BASE + 8'h01, 32'h0);
        checked_access(RW_READ, `SYS_INFO_BASE + 8'h02, 32'h0);
        checked_access(RW_READ, `SYS_INFO_BASE + 8'h03, 32'h0);
        checked_access(RW_READ, `SYS_INFO_BASE + 8'h03, 32'h0);
        checked_access(RW_READ, `SYS_INFO_BASE + 8'h02, 32'h0);

        // random transfers biased toward both blocks and their edges
        for (int i = 0; i < NUM_RANDOM; i++) begin
            case ($urandom_range(2, 0))
                0:       addr = `SYS_INFO_BASE + 8'($urandom_range(4, 0));
                1:       addr = `PWM_BASE + 8'($urandom_range(3, 0));
                default: addr = 8'($urandom_range(255, 0));
            endcase
            rw = ($urandom_range(1, 0) == 1) ? RW_WRITE : RW_READ;
            checked_access(rw, addr, $urandom());
        end

        // pwm output windows
        for (int i = 0; i < NUM_PWM_CASES; i++) begin
            pwm_window_test($urandom_range(40, 1), $urandom_range(45, 0));
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+src
src/bus_pkg.sv
src/sys_pkg.sv
src/bus_ctrl.sv
src/sys_info.sv
src/pwm_block.sv
src/bus_response.sv
src/reg_subsystem_top.sv
verification/tb_reg_subsystem.sv
